// File: include/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// datapath width, one word
`define ALU_WIDTH 32

// apb byte address width
`define APB_ADDR_WIDTH 8

// register map, byte offsets
`define REG_OPA    8'h00
`define REG_OPB    8'h04
`define REG_CMD    8'h08
`define REG_RESULT 8'h0C // read only
`define REG_FLAGS  8'h10 // read only

// number of command bits kept from a REG_CMD write
`define CMD_WIDTH 3

`endif

// File: project.f
+incdir+include
rtl/aluPkg.sv
rtl/aluControl.sv
rtl/aluBitSlice.sv
rtl/aluOutputStage.sv
rtl/aluApbRegs.sv
rtl/aluApbTop.sv
test/aluTb.sv

// File: rtl/aluApbRegs.sv
`include "alu_settings.svh"

module aluApbRegs (
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  aluPkg::apbAddr_t  paddr,
  input  aluPkg::word_t     pwdata,
  output aluPkg::word_t     prdata,
  output logic              pready,
  output logic              pslverr,
  input  aluPkg::word_t     result,
  input  aluPkg::aluFlags_t flags,
  output aluPkg::word_t     opA,
  output aluPkg::word_t     opB,
  output aluPkg::aluCmd_t   cmd
);

  import aluPkg::*;

  logic access;
  logic hitOpA;
  logic hitOpB;
  logic hitCmd;
  logic hitResult;
  logic hitFlags;
  logic mapped;
  logic readOnlyHit;

  assign access = psel & penable; // apb access phase

  // address decode
  assign hitOpA    = (paddr == `REG_OPA);
  assign hitOpB    = (paddr == `REG_OPB);
  assign hitCmd    = (paddr == `REG_CMD);
  assign hitResult = (paddr == `REG_RESULT);
  assign hitFlags  = (paddr == `REG_FLAGS);

  assign readOnlyHit = hitResult | hitFlags;
  assign mapped      = hitOpA | hitOpB | hitCmd | readOnlyHit;

  // no wait states
  assign pready = 1'b1;

  // unmapped address, or a write to a read-only register
  assign pslverr = access & (~mapped | (pwrite & readOnlyHit));

  // writable registers
  always_ff @(posedge clk) begin
    if (reset) begin
      opA <= '0;
      opB <= '0;
      cmd <= ADD;
    end else if (access && pwrite) begin
      if (hitOpA) begin
        opA <= pwdata;
      end
      if (hitOpB) begin
        opB <= pwdata;
      end
      if (hitCmd) begin
        cmd <= aluCmd_t'(pwdata[`CMD_WIDTH-1:0]); // upper bits dropped
      end
    end
  end

  // read mux, zero for unmapped
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (hitOpA) begin
        prdata = opA;
      end else if (hitOpB) begin
        prdata = opB;
      end else if (hitCmd) begin
        prdata = word_t'(cmd);
      end else if (hitResult) begin
        prdata = result;
      end else if (hitFlags) begin
        prdata = {{(`ALU_WIDTH - $bits(aluFlags_t)){1'b0}}, flags};
      end
    end
  end

endmodule

// File: rtl/aluApbTop.sv
`include "alu_settings.svh"

module aluApbTop (
  input  logic             clk,
  input  logic             reset,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  aluPkg::apbAddr_t paddr,
  input  aluPkg::word_t    pwdata,
  output aluPkg::word_t    prdata,
  output logic             pready,
  output logic             pslverr
);

  import aluPkg::*;

  word_t      opA;
  word_t      opB;
  aluCmd_t    cmd;
  sliceCtrl_t ctrl;
  word_t      sliceOut;
  word_t      result;
  aluFlags_t  flags;

  logic [`ALU_WIDTH:0] carry; // ripple chain, carry[i] enters slice i

  aluApbRegs u_aluApbRegs (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .result  (result),
    .flags   (flags),
    .opA     (opA),
    .opB     (opB),
    .cmd     (cmd)
  );

  aluControl u_aluControl (
    .cmd  (cmd),
    .ctrl (ctrl)
  );

  assign carry[0] = ctrl.carryIn;

  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : gSlice
    aluBitSlice u_aluBitSlice (
      .a        (opA[i]),
      .b        (opB[i]),
      .carryIn  (carry[i]),
      .ctrl     (ctrl),
      .out      (sliceOut[i]),
      .carryOut (carry[i+1])
    );
  end

  aluOutputStage u_aluOutputStage (
    .sliceOut     (sliceOut),
    .carryIntoMsb (carry[`ALU_WIDTH-1]),
    .carryOutMsb  (carry[`ALU_WIDTH]),
    .cmd          (cmd),
    .result       (result),
    .flags        (flags)
  );

endmodule

// File: rtl/aluBitSlice.sv
module aluBitSlice (
  input  logic               a,
  input  logic               b,
  input  logic               carryIn,
  input  aluPkg::sliceCtrl_t ctrl,
  output logic               out,
  output logic               carryOut
);

  import aluPkg::*;

  logic aIn;
  logic bIn;
  logic halfSum;
  logic sum;

  assign aIn = a ^ ctrl.invertA; // conditional inversion
  assign bIn = b ^ ctrl.invertB;

  // full adder
  assign halfSum  = aIn ^ bIn;
  assign sum      = halfSum ^ carryIn;
  assign carryOut = (aIn & bIn) | (halfSum & carryIn);

  // per-bit function select
  always_comb begin
    case (ctrl.op)
      OP_SUM:  out = sum;
      OP_AND:  out = aIn & bIn;
      OP_OR:   out = aIn | bIn;
      OP_XOR:  out = halfSum;
      default: out = sum;
    endcase
  end

endmodule

// File: rtl/aluControl.sv
module aluControl (
  input  aluPkg::aluCmd_t    cmd,
  output aluPkg::sliceCtrl_t ctrl
);

  import aluPkg::*;

  // command to slice control lookup
  always_comb begin
    ctrl = '0;
    case (cmd)
      ADD: begin
        ctrl.op = OP_SUM;
      end
      SUB: begin // a + ~b + 1
        ctrl.invertB = 1'b1;
        ctrl.carryIn = 1'b1;
        ctrl.op      = OP_SUM;
      end
      XOR: begin
        ctrl.op = OP_XOR;
      end
      SLT: begin
        // same subtract as SUB, output stage picks the sign
        ctrl.invertB = 1'b1;
        ctrl.carryIn = 1'b1;
        ctrl.op      = OP_SUM;
      end
      AND: begin
        ctrl.op = OP_AND;
      end
      NAND: begin // ~a | ~b
        ctrl.invertA = 1'b1;
        ctrl.invertB = 1'b1;
        ctrl.op      = OP_OR;
      end
      NOR: begin // ~a & ~b
        ctrl.invertA = 1'b1;
        ctrl.invertB = 1'b1;
        ctrl.op      = OP_AND;
      end
      OR: begin
        ctrl.op = OP_OR;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// File: rtl/aluOutputStage.sv
`include "alu_settings.svh"

module aluOutputStage (
  input  aluPkg::word_t     sliceOut,
  input  logic              carryIntoMsb,
  input  logic              carryOutMsb,
  input  aluPkg::aluCmd_t   cmd,
  output aluPkg::word_t     result,
  output aluPkg::aluFlags_t flags
);

  import aluPkg::*;

  logic overflowRaw;
  logic lessThan;
  logic isArith;

  // signed overflow of the ripple adder
  assign overflowRaw = carryIntoMsb ^ carryOutMsb;

  // sign of a-b corrected by overflow
  assign lessThan = sliceOut[`ALU_WIDTH-1] ^ overflowRaw;

  assign isArith = (cmd == ADD) || (cmd == SUB);

  always_comb begin
    if (cmd == SLT) begin
      result = word_t'(lessThan); // slt bit in bit 0, zeros above
    end else begin
      result = sliceOut;
    end
  end

  // carry and overflow only mean something for add and sub
  assign flags.carryOut = isArith & carryOutMsb;
  assign flags.overflow = isArith & overflowRaw;
  assign flags.zero     = (result == '0);

endmodule

// File: rtl/aluPkg.sv
`include "alu_settings.svh"

package aluPkg;

  // operand and result word
  typedef logic [`ALU_WIDTH-1:0] word_t;

  typedef logic [`APB_ADDR_WIDTH-1:0] apbAddr_t;

  // command codes as seen in REG_CMD
  typedef enum logic [`CMD_WIDTH-1:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    XOR  = 3'd2,
    SLT  = 3'd3,
    AND  = 3'd4,
    NAND = 3'd5,
    NOR  = 3'd6,
    OR   = 3'd7
  } aluCmd_t;

  // function picked inside each bit slice
  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_AND = 2'd1,
    OP_OR  = 2'd2,
    OP_XOR = 2'd3
  } sliceOp_t;

  typedef struct packed {
    logic     invertA;
    logic     invertB;
    logic     carryIn; // carry into slice 0
    sliceOp_t op;
  } sliceCtrl_t;

  // bit order matches REG_FLAGS: carryOut[2], overflow[1], zero[0]
  typedef struct packed {
    logic carryOut;
    logic overflow;
    logic zero;
  } aluFlags_t;

endpackage

// File: run.sh
#!/bin/sh
# build aluTb with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module aluTb -o aluSim \
  && simOut="$(./obj_dir/aluSim)" \
  && printf '%s\n' "$simOut" \
  && printf '%s\n' "$simOut" | grep -q "TEST RESULT: PASS" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: test/aluTb.sv
`include "alu_settings.svh"

module aluTb;
  timeunit 1ns;
  timeprecision 1ps;

  import aluPkg::*;

  // about 250 ops of about 12 cycles each, plus margin
  localparam int CYCLE_LIMIT = 4000;

  typedef logic [`ALU_WIDTH:0] wide_t; // word plus carry

  typedef struct packed {
    word_t     result;
    aluFlags_t flags;
  } aluExpect_t;

  // one observed operation, handed to the comparator
  typedef struct packed {
    word_t   a;
    word_t   b;
    aluCmd_t cmd;
    word_t   result;
    word_t   flagsWord;
    logic    slvErr; // any pslverr during the op
  } opRecord_t;

  logic     clk;
  logic     reset;
  logic     psel;
  logic     penable;
  logic     pwrite;
  apbAddr_t paddr;
  word_t    pwdata;
  word_t    prdata;
  logic     pready;
  logic     pslverr;

  int         seed;
  int         cycleCount = 0;
  int         passCount = 0;
  int         errorCount = 0;
  opRecord_t  rec;
  aluExpect_t expected;
  event       opObserved;

  aluApbTop u_aluApbTop (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // expected result and flags
  function automatic aluExpect_t aluModel(input word_t a, input word_t b, input aluCmd_t cmd);
    aluExpect_t e;
    wide_t      wide;
    e = '0;
    case (cmd)
      ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        e.result = wide[`ALU_WIDTH-1:0];
        e.flags.carryOut = wide[`ALU_WIDTH];
        // same-sign operands giving a different-sign sum
        e.flags.overflow = (a[`ALU_WIDTH-1] == b[`ALU_WIDTH-1]) &&
                           (e.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
      end
      SUB: begin
        wide = {1'b0, a} + {1'b0, ~b} + wide_t'(1);
        e.result = wide[`ALU_WIDTH-1:0];
        e.flags.carryOut = wide[`ALU_WIDTH];
        e.flags.overflow = (a[`ALU_WIDTH-1] != b[`ALU_WIDTH-1]) &&
                           (e.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
      end
      XOR:  e.result = a ^ b;
      SLT:  e.result = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      AND:  e.result = a & b;
      NAND: e.result = ~(a & b);
      NOR:  e.result = ~(a | b);
      OR:   e.result = a | b;
      default: e.result = '0;
    endcase
    e.flags.zero = (e.result == '0);
    return e;
  endfunction

  task automatic checkValue(input string name, input word_t actual, input word_t expValue);
    if (actual !== expValue) begin
      $display("Error: %s actual 0x%08h expected 0x%08h", name, actual, expValue);
      errorCount++;
    end else begin
      passCount++;
    end
  endtask

  task automatic apbWrite(input apbAddr_t addr, input word_t data, output logic slvErr);
    @(negedge clk); // setup phase
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1; // access phase
    @(posedge clk);
    slvErr = pslverr;
  endtask

  task automatic apbRead(input apbAddr_t addr, output word_t data, output logic slvErr);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data   = prdata;
    slvErr = pslverr;
  endtask

  task automatic releaseBus();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic writeCheck(input apbAddr_t addr, input word_t data, input logic expectErr);
    logic err;
    apbWrite(addr, data, err);
    checkValue($sformatf("pslverr write 0x%02h", addr), word_t'(err), word_t'(expectErr));
  endtask

  task automatic readCheck(input apbAddr_t addr, input string name, input word_t expValue,
                           input logic expectErr);
    logic  err;
    word_t data;
    apbRead(addr, data, err);
    checkValue(name, data, expValue);
    checkValue($sformatf("%s pslverr", name), word_t'(err), word_t'(expectErr));
  endtask

  // full op through the bus, then hand it to the comparator
  task automatic runOp(input word_t a, input word_t b, input aluCmd_t cmd);
    logic  e0;
    logic  e1;
    logic  e2;
    logic  e3;
    logic  e4;
    word_t res;
    word_t flg;
    apbWrite(`REG_OPA, a, e0);
    apbWrite(`REG_OPB, b, e1);
    apbWrite(`REG_CMD, word_t'(cmd), e2);
    apbRead(`REG_RESULT, res, e3);
    apbRead(`REG_FLAGS, flg, e4);
    releaseBus();
    rec.a         = a;
    rec.b         = b;
    rec.cmd       = cmd;
    rec.result    = res;
    rec.flagsWord = flg;
    rec.slvErr    = e0 | e1 | e2 | e3 | e4;
    -> opObserved;
  endtask

  task automatic randomOp(input aluCmd_t cmd);
    word_t a;
    word_t b;
    a = $random(seed);
    b = $random(seed);
    runOp(a, b, cmd);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    @(posedge clk); // let the comparator catch up
    $display("test %s finished with %0d errors", name, errorCount - errorsBefore);
  endtask

  // comparator
  always @(opObserved) begin
    expected = aluModel(rec.a, rec.b, rec.cmd);
    checkValue($sformatf("%s result", rec.cmd.name()), rec.result, expected.result);
    checkValue($sformatf("%s flags", rec.cmd.name()), rec.flagsWord, word_t'(expected.flags));
    checkValue($sformatf("%s pslverr", rec.cmd.name()), word_t'(rec.slvErr), word_t'(0));
  end

  initial begin
    int         errorsBefore;
    aluExpect_t orExpect;
    seed    = 14548;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errorsBefore = errorCount;
    readCheck(`REG_OPA, "REG_OPA", 32'h0, 1'b0);
    readCheck(`REG_OPB, "REG_OPB", 32'h0, 1'b0);
    readCheck(`REG_CMD, "REG_CMD", 32'h0, 1'b0);
    readCheck(`REG_RESULT, "REG_RESULT", 32'h0, 1'b0);
    readCheck(`REG_FLAGS, "REG_FLAGS", 32'h1, 1'b0); // zero set
    writeCheck(`REG_OPA, 32'h1234_5678, 1'b0);
    writeCheck(`REG_OPB, 32'h9ABC_DEF0, 1'b0);
    writeCheck(`REG_CMD, 32'hFFFF_FFF9, 1'b0); // only bits 2:0 stick
    readCheck(`REG_OPA, "REG_OPA", 32'h1234_5678, 1'b0);
    readCheck(`REG_OPB, "REG_OPB", 32'h9ABC_DEF0, 1'b0);
    readCheck(`REG_CMD, "REG_CMD", 32'h1, 1'b0);
    checkValue("pready", word_t'(pready), 32'h1);
    releaseBus();
    reportTest("reset and readback", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < 50; i++) begin
      randomOp(ADD);
      randomOp(SUB);
    end
    runOp(32'h7FFF_FFFF, 32'h1, ADD); // signed overflow
    runOp(32'h7FFF_FFFF, 32'h1, SUB);
    runOp(32'h8000_0000, 32'h1, SUB);
    runOp(32'h8000_0000, 32'h1, ADD);
    runOp(32'hFFFF_FFFF, 32'h1, ADD); // carry out, zero result
    runOp(32'hFFFF_FFFF, 32'h1, SUB);
    reportTest("add and sub", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < 12; i++) begin
      randomOp(XOR);
      randomOp(AND);
      randomOp(OR);
      randomOp(NAND);
      randomOp(NOR);
    end
    reportTest("logic ops", errorsBefore);

    errorsBefore = errorCount;
    for (int i = 0; i < 40; i++) begin
      randomOp(SLT);
    end
    runOp(32'h8000_0000, 32'h0000_0001, SLT);
    runOp(32'h0000_0001, 32'h8000_0000, SLT);
    runOp(32'h8000_0000, 32'h7FFF_FFFF, SLT);
    runOp(32'hFFFF_FFFF, 32'h0000_0000, SLT);
    runOp(32'h0000_0005, 32'h0000_0005, SLT); // equal
    runOp(32'h8000_0000, 32'h8000_0000, SLT);
    reportTest("set less than", errorsBefore);

    errorsBefore = errorCount;
    orExpect = aluModel(32'h0000_00F0, 32'h0000_000F, OR);
    writeCheck(`REG_OPA, 32'h0000_00F0, 1'b0);
    writeCheck(`REG_OPB, 32'h0000_000F, 1'b0);
    writeCheck(`REG_CMD, 32'h7, 1'b0);
    writeCheck(`REG_RESULT, 32'hDEAD_BEEF, 1'b1);
    writeCheck(`REG_FLAGS, 32'h7, 1'b1);
    writeCheck(8'h40, 32'h1111_1111, 1'b1); // unmapped write
    readCheck(8'h14, "unmapped 0x14", 32'h0, 1'b1);
    readCheck(`REG_OPA, "REG_OPA", 32'h0000_00F0, 1'b0);
    readCheck(`REG_OPB, "REG_OPB", 32'h0000_000F, 1'b0);
    readCheck(`REG_CMD, "REG_CMD", 32'h7, 1'b0);
    readCheck(`REG_RESULT, "REG_RESULT", orExpect.result, 1'b0);
    readCheck(`REG_FLAGS, "REG_FLAGS", word_t'(orExpect.flags), 1'b0);
    releaseBus();
    reportTest("bus errors", errorsBefore);

    $display("checks passed %0d, errors %0d", passCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
